// ==== ps2_port.f ====
source/ps2_pkg.sv
source/bus_pkg.sv
source/ps2_line_filter.sv
source/ps2_receiver.sv
source/ps2_transmitter.sv
source/ps2_regs.sv
source/ps2_port.sv
testbench/ps2_device_model.sv
testbench/tb_ps2_port.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ps2_port -f ps2_port.f

sim_status=0
./obj_dir/Vtb_ps2_port > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
exit "$sim_status"

// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// register index, bit 1 is ignored
	// 0 data, 1 status, 2 and 3 alias them
	typedef logic [1:0] bus_addr_t;

	typedef logic [7:0] bus_data_t;

	// master side, held until ack is seen
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		bus_addr_t adr;
		bus_data_t dat;
	} bus_req_t;

	typedef struct packed {
		logic      ack;
		bus_data_t dat;
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== source/ps2_line_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_line_filter (
	input  wire logic          clk_i,
	input  wire logic          rst_i,
	input  wire logic          kclk_i,
	input  wire logic          kdat_i,
	output ps2_pkg::ps2_line_t line_o
);

	// clock pin goes through a long chain, data through a short sync
	// plus a majority window, so data settles well before an edge shows
	localparam int CLK_SYNC_LEN = 10;
	localparam int DAT_WIN_LEN  = 7;

	logic [CLK_SYNC_LEN-1:0] clk_sync_q;
	logic [1:0]              dat_meta_q;
	logic [DAT_WIN_LEN-1:0]  dat_win_q;
	logic [2:0]              dat_ones;
	logic                    clk_now;
	ps2_pkg::ps2_line_t      line_q;

	assign clk_now = clk_sync_q[CLK_SYNC_LEN-1];

	// count high samples in the window
	always_comb begin
		dat_ones = '0;
		for (int i = 0; i < DAT_WIN_LEN; i++) begin
			dat_ones = dat_ones + 3'(dat_win_q[i]);
		end
	end

	// ======================================================================
	// sync chains and edge flags
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			// idle bus is high on both wires
			clk_sync_q <= '1;
			dat_meta_q <= '1;
			dat_win_q  <= '1;
			line_q     <= '{clk_level: 1'b1, clk_fall: 1'b0, clk_rise: 1'b0, dat_level: 1'b1};
		end else begin
			clk_sync_q <= {clk_sync_q[CLK_SYNC_LEN-2:0], kclk_i};
			dat_meta_q <= {dat_meta_q[0], kdat_i};
			dat_win_q  <= {dat_win_q[DAT_WIN_LEN-2:0], dat_meta_q[1]};
			// clk_level doubles as the previous level for edge detect
			line_q.clk_level <= clk_now;
			line_q.clk_fall  <= line_q.clk_level & ~clk_now;
			line_q.clk_rise  <= ~line_q.clk_level & clk_now;
			// four of seven wins
			line_q.dat_level <= (dat_ones >= 3'd4);
		end
	end

	assign line_o = line_q;

endmodule

`default_nettype wire

// ==== source/ps2_pkg.sv ====
`default_nettype none

package ps2_pkg;

	// one data byte of a device frame
	typedef logic [7:0] ps2_byte_t;

	// full frame as shifted in, LSB first
	// bit 0 start, 8:1 data, 9 parity, 10 stop
	typedef logic [10:0] ps2_frame_t;

	// filtered view of the two wires
	// edge flags are single-cycle strobes
	typedef struct packed {
		logic clk_level;
		logic clk_fall;
		logic clk_rise;
		logic dat_level;
	} ps2_line_t;

	// receiver state seen by the register block
	typedef struct packed {
		logic      full;
		ps2_byte_t data;
		logic      parity_err;
	} ps2_rx_t;

	// host-to-device sequencer
	typedef enum logic [4:0] {
		TX_IDLE,
		TX_REQUEST,
		TX_HOLD,
		TX_DATA_LOW,
		TX_RELEASE,
		TX_WAIT_FALL,
		TX_SETTLE,
		TX_SHIFT,
		TX_WAIT_ACK_FALL,
		TX_CAPTURE_ACK,
		TX_WAIT_RISE,
		TX_DONE
	} ps2_tx_state_t;

endpackage

`default_nettype wire

// ==== source/ps2_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_port #(
	parameter int CLK_FREQ_HZ = 50_000_000
) (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire bus_pkg::bus_req_t bus_req_i,
	input  wire logic              kclk_i,
	input  wire logic              kdat_i,
	output bus_pkg::bus_rsp_t      bus_rsp_o,
	output logic                   irq_o,
	output logic                   kclk_en_o,
	output logic                   kdat_en_o
);

	// 5 us debounce, 100 us request-to-send
	localparam int DEBOUNCE_CYCLES = CLK_FREQ_HZ / 200_000;
	localparam int RTS_CYCLES      = CLK_FREQ_HZ / 10_000;

	ps2_pkg::ps2_line_t line;
	ps2_pkg::ps2_rx_t   rx;
	ps2_pkg::ps2_byte_t tx_data;
	logic               hold_clk_low;
	logic               rx_clear;
	logic               tx_start;
	logic               tx_abort;
	logic               tx_busy;
	logic               ack_ok;
	logic               tx_clk_low;
	logic               tx_dat_low;

	ps2_line_filter line_filter_inst (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.kclk_i (kclk_i),
		.kdat_i (kdat_i),
		.line_o (line)
	);

	ps2_receiver #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) receiver_inst (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.line_i         (line),
		.tx_busy_i      (tx_busy),
		.rx_clear_i     (rx_clear),
		.rx_o           (rx),
		.hold_clk_low_o (hold_clk_low)
	);

	ps2_transmitter #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.RTS_CYCLES      (RTS_CYCLES)
	) transmitter_inst (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.line_i     (line),
		.tx_start_i (tx_start),
		.tx_data_i  (tx_data),
		.tx_abort_i (tx_abort),
		.tx_busy_o  (tx_busy),
		.ack_ok_o   (ack_ok),
		.clk_low_o  (tx_clk_low),
		.dat_low_o  (tx_dat_low)
	);

	ps2_regs regs_inst (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.bus_req_i  (bus_req_i),
		.rx_i       (rx),
		.tx_busy_i  (tx_busy),
		.ack_ok_i   (ack_ok),
		.bus_rsp_o  (bus_rsp_o),
		.rx_clear_o (rx_clear),
		.tx_start_o (tx_start),
		.tx_data_o  (tx_data),
		.tx_abort_o (tx_abort)
	);

	// open-collector enables, 1 pulls the wire low
	// unread byte keeps the device inhibited
	assign kclk_en_o = tx_clk_low | hold_clk_low;
	assign kdat_en_o = tx_dat_low;
	assign irq_o     = rx.full;

endmodule

`default_nettype wire

// ==== source/ps2_receiver.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_receiver #(
	parameter int DEBOUNCE_CYCLES = 250
) (
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  wire ps2_pkg::ps2_line_t line_i,
	input  wire logic               tx_busy_i,
	input  wire logic               rx_clear_i,
	output ps2_pkg::ps2_rx_t        rx_o,
	output logic                    hold_clk_low_o
);

	localparam int TIMER_W = $clog2(DEBOUNCE_CYCLES + 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DEBOUNCE,
		RX_CAPTURE
	} rx_state_t;

	rx_state_t           state_q;
	logic [TIMER_W-1:0]  timer_q;
	ps2_pkg::ps2_frame_t frame_q;
	logic                hold_q;
	logic                frame_full;

	// start bit (always 0) lands in bit 0 after the eleventh shift
	assign frame_full = ~frame_q[0];

	// ======================================================================
	// receive state machine
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= RX_IDLE;
			timer_q <= '0;
			frame_q <= '1;
			hold_q  <= 1'b0;
		end else begin
			timer_q <= timer_q + 1'b1;
			case (state_q)
			RX_IDLE: begin
				timer_q <= '0;
				// no new bits while a byte is unread or host is sending
				if (line_i.clk_fall && !tx_busy_i && !frame_full) begin
					state_q <= RX_DEBOUNCE;
				end
			end
			RX_DEBOUNCE: begin
				if (tx_busy_i) begin
					state_q <= RX_IDLE;
				end else if (timer_q == TIMER_W'(DEBOUNCE_CYCLES - 1)) begin
					// clock back high means a glitch, drop it
					state_q <= line_i.clk_level ? RX_IDLE : RX_CAPTURE;
				end
			end
			RX_CAPTURE: begin
				if (!tx_busy_i) begin
					frame_q <= {line_i.dat_level, frame_q[10:1]};
					// this shift moves the start bit into place
					if (!frame_q[1]) begin
						hold_q <= 1'b1;
					end
				end
				state_q <= RX_IDLE;
			end
			default: state_q <= RX_IDLE;
			endcase
			if (rx_clear_i) begin
				frame_q <= '1;
				hold_q  <= 1'b0;
			end
		end
	end

	// odd parity over data and parity bit
	assign rx_o = '{
		full:       frame_full,
		data:       frame_q[8:1],
		parity_err: frame_full & ~(^frame_q[9:1])
	};
	assign hold_clk_low_o = hold_q;

	// encoding never drifts to the unused value
	assert property (@(posedge clk_i) disable iff (rst_i)
		state_q inside {RX_IDLE, RX_DEBOUNCE, RX_CAPTURE});

	// inhibit tracks the frame through capture and clear
	assert property (@(posedge clk_i) disable iff (rst_i)
		hold_q == frame_full);

endmodule

`default_nettype wire

// ==== source/ps2_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_regs (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire bus_pkg::bus_req_t bus_req_i,
	input  wire ps2_pkg::ps2_rx_t  rx_i,
	input  wire logic              tx_busy_i,
	input  wire logic              ack_ok_i,
	output bus_pkg::bus_rsp_t      bus_rsp_o,
	output logic                   rx_clear_o,
	output logic                   tx_start_o,
	output ps2_pkg::ps2_byte_t     tx_data_o,
	output logic                   tx_abort_o
);

	logic               req_active;
	logic               req_first;
	logic               sel_status;
	logic               wr_first;
	logic               ack_q;
	bus_pkg::bus_data_t rd_data;
	bus_pkg::bus_data_t rd_data_q;
	ps2_pkg::ps2_byte_t tx_data_q;

	assign req_active = bus_req_i.cyc & bus_req_i.stb;
	// ack still low means this is the opening cycle
	assign req_first  = req_active & ~ack_q;
	// bit 1 of the address is not decoded
	assign sel_status = bus_req_i.adr[0];
	assign wr_first   = req_first & bus_req_i.we;

	// status layout: irq, tc, ack_ok, four zeros, parity_err
	always_comb begin
		if (sel_status) begin
			rd_data = {rx_i.full, ~tx_busy_i, ack_ok_i, 4'b0000, rx_i.parity_err};
		end else begin
			rd_data = rx_i.data;
		end
	end

	// ======================================================================
	// ack and control pulses
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_q      <= 1'b0;
			rx_clear_o <= 1'b0;
			tx_start_o <= 1'b0;
			tx_abort_o <= 1'b0;
		end else begin
			ack_q      <= req_active;
			tx_start_o <= wr_first & ~sel_status;
			rx_clear_o <= wr_first & sel_status & (bus_req_i.dat == 8'h00);
			tx_abort_o <= wr_first & sel_status & (bus_req_i.dat == 8'hFF);
		end
	end

	// read data and transmit byte
	always_ff @(posedge clk_i) begin
		if (req_first) begin
			rd_data_q <= rd_data;
		end
		if (wr_first & ~sel_status) begin
			tx_data_q <= bus_req_i.dat;
		end
	end

	assign bus_rsp_o = '{ack: ack_q, dat: rd_data_q};
	assign tx_data_o = tx_data_q;

	// side effects never overlap
	assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0({rx_clear_o, tx_start_o, tx_abort_o}));

endmodule

`default_nettype wire

// ==== source/ps2_transmitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_transmitter #(
	parameter int DEBOUNCE_CYCLES = 250,
	parameter int RTS_CYCLES      = 5000
) (
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  wire ps2_pkg::ps2_line_t line_i,
	input  wire logic               tx_start_i,
	input  wire ps2_pkg::ps2_byte_t tx_data_i,
	input  wire logic               tx_abort_i,
	output logic                    tx_busy_o,
	output logic                    ack_ok_o,
	output logic                    clk_low_o,
	output logic                    dat_low_o
);

	localparam int TIMER_MAX  = (RTS_CYCLES > DEBOUNCE_CYCLES) ? RTS_CYCLES : DEBOUNCE_CYCLES;
	localparam int TIMER_W    = $clog2(TIMER_MAX + 1);
	// start, eight data, parity, stop
	localparam int FRAME_BITS = 11;

	ps2_pkg::ps2_tx_state_t state_q;
	logic [TIMER_W-1:0]     timer_q;
	logic                   debounce_done;
	logic                   rts_done;
	ps2_pkg::ps2_frame_t    shift_q;
	logic [3:0]             bit_cnt_q;
	logic                   busy_q;
	logic                   ack_ok_q;
	logic                   clk_low_q;
	logic                   dat_drive_q;
	logic                   shift_en;

	assign debounce_done = (timer_q == TIMER_W'(DEBOUNCE_CYCLES - 1));
	assign rts_done      = (timer_q == TIMER_W'(RTS_CYCLES - 1));
	assign shift_en      = (state_q == ps2_pkg::TX_SHIFT) && line_i.clk_rise;

	// ======================================================================
	// host-to-device sequencer
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q     <= ps2_pkg::TX_IDLE;
			timer_q     <= '0;
			bit_cnt_q   <= '0;
			busy_q      <= 1'b0;
			ack_ok_q    <= 1'b0;
			clk_low_q   <= 1'b0;
			dat_drive_q <= 1'b0;
		end else if (tx_abort_i) begin
			// let go of both wires, tc reads back set
			state_q     <= ps2_pkg::TX_IDLE;
			busy_q      <= 1'b0;
			clk_low_q   <= 1'b0;
			dat_drive_q <= 1'b0;
		end else if (tx_start_i) begin
			// a start while busy restarts from the top
			state_q     <= ps2_pkg::TX_REQUEST;
			timer_q     <= '0;
			bit_cnt_q   <= 4'(FRAME_BITS);
			busy_q      <= 1'b1;
			ack_ok_q    <= 1'b0;
			dat_drive_q <= 1'b0;
		end else begin
			timer_q <= timer_q + 1'b1;
			case (state_q)
			ps2_pkg::TX_IDLE: timer_q <= '0;
			ps2_pkg::TX_REQUEST: begin
				// inhibit the device first
				clk_low_q <= 1'b1;
				timer_q   <= '0;
				state_q   <= ps2_pkg::TX_HOLD;
			end
			ps2_pkg::TX_HOLD: begin
				if (rts_done) begin
					state_q <= ps2_pkg::TX_DATA_LOW;
				end
			end
			ps2_pkg::TX_DATA_LOW: begin
				// start bit goes out while clock still held
				dat_drive_q <= 1'b1;
				timer_q     <= '0;
				state_q     <= ps2_pkg::TX_RELEASE;
			end
			ps2_pkg::TX_RELEASE: begin
				if (debounce_done) begin
					clk_low_q <= 1'b0;
					state_q   <= ps2_pkg::TX_WAIT_FALL;
				end
			end
			ps2_pkg::TX_WAIT_FALL: begin
				// device takes over clocking
				if (line_i.clk_fall) begin
					timer_q <= '0;
					state_q <= ps2_pkg::TX_SETTLE;
				end
			end
			ps2_pkg::TX_SETTLE: begin
				if (debounce_done) begin
					state_q <= ps2_pkg::TX_SHIFT;
				end
			end
			ps2_pkg::TX_SHIFT: begin
				// one bit per rising edge, last rise leaves the line released
				if (line_i.clk_rise) begin
					bit_cnt_q <= bit_cnt_q - 1'b1;
					if (bit_cnt_q == 4'd1) begin
						state_q <= ps2_pkg::TX_WAIT_ACK_FALL;
					end
				end
			end
			ps2_pkg::TX_WAIT_ACK_FALL: begin
				if (line_i.clk_fall) begin
					timer_q <= '0;
					state_q <= ps2_pkg::TX_CAPTURE_ACK;
				end
			end
			ps2_pkg::TX_CAPTURE_ACK: begin
				// device holds data low in the ack slot
				if (debounce_done) begin
					ack_ok_q <= ~line_i.dat_level;
					state_q  <= ps2_pkg::TX_WAIT_RISE;
				end
			end
			ps2_pkg::TX_WAIT_RISE: begin
				if (line_i.clk_rise) begin
					state_q <= ps2_pkg::TX_DONE;
				end
			end
			ps2_pkg::TX_DONE: begin
				busy_q      <= 1'b0;
				dat_drive_q <= 1'b0;
				state_q     <= ps2_pkg::TX_IDLE;
			end
			default: state_q <= ps2_pkg::TX_IDLE;
			endcase
		end
	end

	// frame register, bit 0 is on the wire
	always_ff @(posedge clk_i) begin
		if (tx_start_i) begin
			shift_q <= {1'b1, ~(^tx_data_i), tx_data_i, 1'b0};
		end else if (shift_en) begin
			shift_q <= {1'b1, shift_q[10:1]};
		end
	end

	assign tx_busy_o = busy_q;
	assign ack_ok_o  = ack_ok_q;
	assign clk_low_o = clk_low_q;
	assign dat_low_o = dat_drive_q & ~shift_q[0];

	// data wire is free whenever the sequencer rests
	assert property (@(posedge clk_i) disable iff (rst_i)
		(state_q == ps2_pkg::TX_IDLE) |-> !dat_low_o);

endmodule

`default_nettype wire

// ==== testbench/ps2_device_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_device_model #(
	parameter int HALF_PERIOD = 60
) (
	input  wire logic clk_i,
	input  wire logic kclk_i,
	input  wire logic kdat_i,
	output logic      clk_en_o,
	output logic      dat_en_o
);

	// enables pull the shared wires low, idle released
	logic clk_en_q = 1'b0;
	logic dat_en_q = 1'b0;

	assign clk_en_o = clk_en_q;
	assign dat_en_o = dat_en_q;

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_i);
	endtask

	// ======================================================================
	// device to host frame
	// ======================================================================
	task automatic send_frame(input logic [7:0] data, input logic parity);
		logic [10:0] bits;
		bits = {1'b1, parity, data, 1'b0};
		// host inhibit keeps the clock low, no bits until it lets go
		do @(posedge clk_i); while (!kclk_i);
		wait_cycles(HALF_PERIOD);
		for (int i = 0; i < 11; i++) begin
			// data changes mid high time, host samples in the low time
			dat_en_q <= ~bits[0];
			bits = {1'b1, bits[10:1]};
			wait_cycles(HALF_PERIOD / 2);
			clk_en_q <= 1'b1;
			wait_cycles(HALF_PERIOD);
			clk_en_q <= 1'b0;
			wait_cycles(HALF_PERIOD / 2);
		end
		dat_en_q <= 1'b0;
	endtask

	// ======================================================================
	// host to device frame
	// ======================================================================
	task automatic accept_host_frame(
		input  logic       give_ack,
		output logic [7:0] data,
		output logic       parity,
		output logic       framing_ok
	);
		logic [10:0] bits;
		bits = '1;
		// request-to-send, clock released with data held low
		do @(posedge clk_i); while (!(kclk_i && !kdat_i));
		wait_cycles(HALF_PERIOD / 2);
		for (int i = 1; i <= 12; i++) begin
			clk_en_q <= 1'b1;
			wait_cycles(HALF_PERIOD / 2);
			// eleven samples, start bit first
			if (i <= 11) begin
				bits = {kdat_i, bits[10:1]};
			end
			wait_cycles(HALF_PERIOD / 2);
			clk_en_q <= 1'b0;
			wait_cycles(HALF_PERIOD / 2);
			// ack slot follows the stop bit
			if (i == 11 && give_ack) begin
				dat_en_q <= 1'b1;
			end
			wait_cycles(HALF_PERIOD / 2);
		end
		dat_en_q <= 1'b0;
		data       = bits[8:1];
		parity     = bits[9];
		framing_ok = ~bits[0] & bits[10];
	endtask

endmodule

`default_nettype wire

// ==== testbench/tb_ps2_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ps2_port;

	localparam int CLK_FREQ_HZ        = 4_000_000;
	localparam int CLK_PERIOD         = 4;
	localparam int RESET_CYCLES       = 5;
	localparam int DEVICE_HALF_PERIOD = 60;
	localparam int TIMEOUT_CYCLES     = 40 * 12_000;
	localparam int BUS_ACK_LIMIT      = 8;
	localparam int IRQ_WAIT_LIMIT     = 400;
	localparam int TX_POLL_LIMIT      = 2000;
	localparam int INHIBIT_CYCLES     = 1500;
	localparam int DATA_LOW_LIMIT     = 600;
	localparam bit [31:0] SEED        = 32'he1bc;

	localparam bus_pkg::bus_addr_t DATA_ADR   = 2'd0;
	localparam bus_pkg::bus_addr_t STATUS_ADR = 2'd1;

	logic              clk;
	logic              rst;
	bus_pkg::bus_req_t bus_req;
	bus_pkg::bus_rsp_t bus_rsp;
	logic              irq;
	logic              kclk_en;
	logic              kdat_en;
	logic              dev_clk_en;
	logic              dev_dat_en;
	wire               kclk_line;
	wire               kdat_line;

	// reference state of the port tracked from the stimulus
	logic exp_ack_ok = 1'b0;
	int   cycle_count = 0;

	// wired-AND where either side pulls low
	assign kclk_line = ~kclk_en & ~dev_clk_en;
	assign kdat_line = ~kdat_en & ~dev_dat_en;

	ps2_port #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ)
	) ps2_port_inst (
		.clk_i     (clk),
		.rst_i     (rst),
		.bus_req_i (bus_req),
		.kclk_i    (kclk_line),
		.kdat_i    (kdat_line),
		.bus_rsp_o (bus_rsp),
		.irq_o     (irq),
		.kclk_en_o (kclk_en),
		.kdat_en_o (kdat_en)
	);

	ps2_device_model #(
		.HALF_PERIOD (DEVICE_HALF_PERIOD)
	) keyboard (
		.clk_i    (clk),
		.kclk_i   (kclk_line),
		.kdat_i   (kdat_line),
		.clk_en_o (dev_clk_en),
		.dat_en_o (dev_dat_en)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ======================================================================
	// reporting and reference helpers
	// ======================================================================
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
		input logic [7:0] expected);
		assert (got === expected) else
			fail_run($sformatf("Error at %0t ns: %s is 0x%02h, expected 0x%02h",
				$time, name, got, expected));
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		assert (got === expected) else
			fail_run($sformatf("Error at %0t ns: %s is %b, expected %b",
				$time, name, got, expected));
	endtask

	// parity bit that makes the count of ones odd
	function automatic logic odd_parity(input logic [7:0] data);
		return ($countones(data) % 2) == 0;
	endfunction

	// irq bit 7, tc bit 6, ack_ok bit 5, parity_err bit 0
	function automatic bus_pkg::bus_data_t status_byte(input logic irq_bit, input logic tc,
		input logic ack, input logic perr);
		return {irq_bit, tc, ack, 4'b0000, perr};
	endfunction

	// run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("Timeout after %0d cycles, the run did not finish", cycle_count));
		end
	end

	// ======================================================================
	// bus access
	// ======================================================================
	task automatic bus_cycle(input logic we, input bus_pkg::bus_addr_t adr,
		input bus_pkg::bus_data_t wdat, output bus_pkg::bus_data_t rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(posedge clk);
			waited++;
		end while (!bus_rsp.ack && waited < BUS_ACK_LIMIT);
		assert (bus_rsp.ack) else fail_run("bus request was never acknowledged");
		rdat = bus_rsp.dat;
		// strobe drops for a cycle before the next request
		bus_req <= '0;
	endtask

	task automatic bus_read(input bus_pkg::bus_addr_t adr, output bus_pkg::bus_data_t rdat);
		bus_cycle(1'b0, adr, 8'h00, rdat);
	endtask

	task automatic bus_write(input bus_pkg::bus_addr_t adr, input bus_pkg::bus_data_t wdat);
		bus_pkg::bus_data_t unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	// ======================================================================
	// receive side
	// ======================================================================
	task automatic wait_for_irq();
		int n;
		n = 0;
		while (!irq && n < IRQ_WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		assert (irq) else fail_run("irq did not rise after a device frame");
	endtask

	task automatic expect_rx(input logic [7:0] data, input logic parity);
		bus_pkg::bus_data_t rd;
		logic exp_perr;
		// good frame has an odd count of ones over data and parity
		exp_perr = ($countones({data, parity}) % 2) == 0;
		check_bit("irq_o", irq, 1'b1);
		check_bit("kclk_en_o", kclk_en, 1'b1);
		bus_read(DATA_ADR, rd);
		check_byte("data register", rd, data);
		// the data read leaves the byte in place
		bus_read(STATUS_ADR, rd);
		check_byte("status register", rd, status_byte(1'b1, 1'b1, exp_ack_ok, exp_perr));
	endtask

	task automatic clear_rx();
		bus_pkg::bus_data_t rd;
		bus_write(STATUS_ADR, 8'h00);
		bus_read(STATUS_ADR, rd);
		check_byte("status register", rd, status_byte(1'b0, 1'b1, exp_ack_ok, 1'b0));
		check_bit("irq_o", irq, 1'b0);
		check_bit("kclk_en_o", kclk_en, 1'b0);
	endtask

	task automatic receive_and_check(input logic [7:0] data, input logic parity);
		keyboard.send_frame(data, parity);
		wait_for_irq();
		expect_rx(data, parity);
		clear_rx();
	endtask

	// ======================================================================
	// transmit side
	// ======================================================================
	task automatic transmit_and_check(input logic [7:0] data, input logic give_ack);
		bus_pkg::bus_data_t rd;
		logic [7:0] got;
		logic       got_parity;
		logic       framing_ok;
		int         polls;
		fork
			keyboard.accept_host_frame(give_ack, got, got_parity, framing_ok);
			begin
				bus_write(DATA_ADR, data);
				exp_ack_ok = 1'b0;
				bus_read(STATUS_ADR, rd);
				check_byte("status register", rd, status_byte(1'b0, 1'b0, 1'b0, 1'b0));
				polls = 0;
				// poll until tc comes back
				do begin
					bus_read(STATUS_ADR, rd);
					polls++;
				end while ((rd & status_byte(1'b0, 1'b1, 1'b0, 1'b0)) == 8'h00
					&& polls < TX_POLL_LIMIT);
				assert ((rd & status_byte(1'b0, 1'b1, 1'b0, 1'b0)) != 8'h00) else
					fail_run("tc did not return to 1 at the end of a transmit");
			end
		join
		exp_ack_ok = give_ack;
		bus_read(STATUS_ADR, rd);
		check_byte("status register", rd, status_byte(1'b0, 1'b1, exp_ack_ok, 1'b0));
		check_byte("device received byte", got, data);
		check_bit("device received parity", got_parity, odd_parity(data));
		check_bit("device start and stop ok", framing_ok, 1'b1);
	endtask

	// start bit goes out once the request-to-send hold ends
	task automatic wait_for_data_low();
		int n;
		n = 0;
		while (!kdat_en && n < DATA_LOW_LIMIT) begin
			@(posedge clk);
			n++;
		end
		assert (kdat_en) else fail_run("kdat_en_o did not rise after the request-to-send hold");
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		bus_pkg::bus_data_t rd;
		logic [7:0] first;
		logic [7:0] second;

		void'($urandom(SEED));
		clk     = 1'b0;
		rst     = 1'b1;
		bus_req = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// quiet after reset with tc reading 1
		bus_read(STATUS_ADR, rd);
		check_byte("status register", rd, status_byte(1'b0, 1'b1, 1'b0, 1'b0));
		check_bit("kclk_en_o", kclk_en, 1'b0);
		check_bit("kdat_en_o", kdat_en, 1'b0);

		// random bytes with good parity
		for (int i = 0; i < 20; i++) begin
			first = 8'($urandom);
			receive_and_check(first, odd_parity(first));
		end

		// flipped parity leaves the data intact
		for (int i = 0; i < 4; i++) begin
			first = 8'($urandom);
			receive_and_check(first, ~odd_parity(first));
		end

		// second frame waits behind the unread byte
		first  = 8'($urandom);
		second = 8'($urandom);
		keyboard.send_frame(first, odd_parity(first));
		wait_for_irq();
		fork
			keyboard.send_frame(second, odd_parity(second));
			begin
				repeat (INHIBIT_CYCLES) begin
					@(posedge clk);
					check_bit("kclk_en_o", kclk_en, 1'b1);
					check_bit("device clock enable", dev_clk_en, 1'b0);
				end
				expect_rx(first, odd_parity(first));
				clear_rx();
			end
		join
		wait_for_irq();
		expect_rx(second, odd_parity(second));
		clear_rx();

		// host to device frames and then one without ack
		for (int i = 0; i < 10; i++) begin
			transmit_and_check(8'($urandom), 1'b1);
		end
		transmit_and_check(8'($urandom), 1'b0);

		// abort while the start bit and the clock hold are both on the wires
		bus_write(DATA_ADR, 8'($urandom));
		exp_ack_ok = 1'b0;
		wait_for_data_low();
		check_bit("kclk_en_o", kclk_en, 1'b1);
		check_bit("kdat_en_o", kdat_en, 1'b1);
		bus_write(STATUS_ADR, 8'hFF);
		bus_read(STATUS_ADR, rd);
		check_byte("status register", rd, status_byte(1'b0, 1'b1, 1'b0, 1'b0));
		check_bit("kclk_en_o", kclk_en, 1'b0);
		check_bit("kdat_en_o", kdat_en, 1'b0);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
